/* logic/ahbl_pkg.sv */
// Shared types for the two-master AHB-Lite slice; full-word transfers only, hburst and hmastlock carried but unused
package ahbl_pkg;

	// Bus geometry
	localparam int N_PORTS   = 2;
	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;

	// SRAM slave depth in words and the byte address limit derived from it
	localparam int MEM_WORDS = 256;
	localparam int MEM_BYTES = MEM_WORDS * (W_DATA / 8);
	localparam int W_MEM_IDX = $clog2(MEM_WORDS);

	typedef logic [W_ADDR-1:0]    addr_t;
	typedef logic [W_DATA-1:0]    data_t;
	typedef logic [N_PORTS-1:0]   port_vec_t;
	typedef logic [7:0]           master_id_t;
	typedef logic [W_MEM_IDX-1:0] mem_idx_t;

	// Ports that are physically wired to a master
	localparam port_vec_t CONN_MASK = '1;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// Only WORD is issued on this bus
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_e;

	// One complete address phase as issued by a master
	typedef struct packed {
		addr_t      haddr;
		logic       hwrite;
		htrans_e    htrans;
		hsize_e     hsize;
		logic [2:0] hburst;
		logic [3:0] hprot;
		logic       hmastlock;
		logic       hexcl;
		master_id_t hmaster;
	} aphase_t;

	// Slave response toward a master
	typedef struct packed {
		logic hready_resp;
		logic hresp;
		logic hexokay;
	} rsp_t;

endpackage

/* logic/ahbl_arb_ctrl.sv */
// Strict-priority arbiter control that assumes each master ties src_hready to its own hready_resp
`timescale 1ns/1ps

module ahbl_arb_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  ahbl_pkg::aphase_t   actual_aphase [ahbl_pkg::N_PORTS],
	input  ahbl_pkg::port_vec_t src_hready,
	input  logic                slv_hready_resp,
	output ahbl_pkg::port_vec_t gnt_a,
	output ahbl_pkg::port_vec_t gnt_d,
	output ahbl_pkg::port_vec_t buf_wen,
	output ahbl_pkg::port_vec_t buf_clr,
	output logic                dst_hready
);

	ahbl_pkg::port_vec_t req;
	ahbl_pkg::port_vec_t aphase_ends;
	ahbl_pkg::port_vec_t gnt_taken;

	// NONSEQ and SEQ both have htrans[1] set
	always_comb begin
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			req[i] = actual_aphase[i].htrans[1] & ahbl_pkg::CONN_MASK[i];
		end
	end

	// Isolate the lowest set bit, which is the highest priority requester
	assign gnt_a = req & (~req + ahbl_pkg::port_vec_t'(1));

	// Slave-side hready follows the slave only while some port owns the data phase
	assign dst_hready = (|gnt_d) ? slv_hready_resp : 1'b1;

	// Address phase is handed to the slave this cycle
	assign gnt_taken = gnt_a & {ahbl_pkg::N_PORTS{dst_hready}};

	// A master finishes its address phase on its own hready
	assign aphase_ends = req & src_hready;

	// Phases that end without reaching the slave are parked in the buffer
	assign buf_wen = aphase_ends & ~gnt_taken;

	// Granted buffers are consumed on the same edge that starts their data phase
	assign buf_clr = gnt_taken;

	// Data phase owner only moves on when the slave is ready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_d <= '0;
		end else if (dst_hready) begin
			gnt_d <= gnt_a;
		end
	end

	// At most one owner in each phase
	a_gnt_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(gnt_a) && $onehot0(gnt_d)
	) else $error("arbiter grant is not one-hot");

	// The data phase owner sees a slave stall on its own hready
	a_owner_stalled: assert property (
		@(posedge clk) disable iff (!rst_n)
		!slv_hready_resp |-> (gnt_d & src_hready) == '0
	) else $error("data phase owner ended an address phase during a slave stall");

	// The slave may only stall a data phase that some port owns
	a_stall_owned: assert property (
		@(posedge clk) disable iff (!rst_n)
		!slv_hready_resp |-> |gnt_d
	) else $error("slave stalled with no data phase owner");

endmodule

/* logic/ahbl_aphase_buf.sv */
// Per-port address phase holding registers; one outstanding parked phase per master at most
`timescale 1ns/1ps

module ahbl_aphase_buf (
	input  logic                clk,
	input  logic                rst_n,
	input  ahbl_pkg::aphase_t   src_aphase [ahbl_pkg::N_PORTS],
	input  ahbl_pkg::port_vec_t buf_wen,
	input  ahbl_pkg::port_vec_t buf_clr,
	output ahbl_pkg::aphase_t   actual_aphase [ahbl_pkg::N_PORTS],
	output ahbl_pkg::port_vec_t buf_valid
);

	ahbl_pkg::aphase_t buf_q [ahbl_pkg::N_PORTS];

	// Load wins over clear, the arbiter never asserts both for one port
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid <= '0;
		end else begin
			for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
				if (buf_wen[i]) begin
					buf_valid[i] <= 1'b1;
				end else if (buf_clr[i]) begin
					buf_valid[i] <= 1'b0;
				end
			end
		end
	end

	// Parked address phase payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			if (buf_wen[i]) begin
				buf_q[i] <= src_aphase[i];
			end
		end
	end

	// A parked phase takes precedence over whatever the master drives now
	always_comb begin
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			actual_aphase[i] = buf_valid[i] ? buf_q[i] : src_aphase[i];
		end
	end

	// A master stalled on its parked phase cannot end another address phase
	a_no_overwrite: assert property (
		@(posedge clk) disable iff (!rst_n)
		(buf_wen & buf_valid) == '0
	) else $error("address phase buffer overwritten while valid");

endmodule

/* logic/ahbl_port_route.sv */
// Grant-driven muxes toward the slave and response fan-out toward the masters; grants must be one-hot
`timescale 1ns/1ps

module ahbl_port_route (
	input  ahbl_pkg::aphase_t   actual_aphase [ahbl_pkg::N_PORTS],
	input  ahbl_pkg::port_vec_t gnt_a,
	input  ahbl_pkg::port_vec_t gnt_d,
	input  ahbl_pkg::port_vec_t buf_valid,
	input  ahbl_pkg::data_t     src_hwdata [ahbl_pkg::N_PORTS],
	input  ahbl_pkg::rsp_t      slv_rsp,
	input  ahbl_pkg::data_t     slv_hrdata,
	output ahbl_pkg::aphase_t   dst_aphase,
	output ahbl_pkg::data_t     dst_hwdata,
	output ahbl_pkg::rsp_t      src_rsp [ahbl_pkg::N_PORTS],
	output ahbl_pkg::data_t     src_hrdata [ahbl_pkg::N_PORTS]
);

	// Master has an outstanding data phase with the arbiter, parked or live
	ahbl_pkg::port_vec_t in_dphase;

	assign in_dphase = buf_valid | gnt_d;

	// With no grant the slave sees an IDLE phase and zero write data
	always_comb begin
		dst_aphase = '0;
		dst_hwdata = '0;
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			if (gnt_a[i]) begin
				dst_aphase = actual_aphase[i];
			end
			if (gnt_d[i]) begin
				dst_hwdata = src_hwdata[i];
			end
		end
	end

	// Ready when idle toward the arbiter, or when owning the slave and the slave is ready
	always_comb begin
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			src_rsp[i].hready_resp = ~in_dphase[i] | (gnt_d[i] & slv_rsp.hready_resp);
			// Error only reaches the data phase owner
			src_rsp[i].hresp       = gnt_d[i] & slv_rsp.hresp;
			src_rsp[i].hexokay     = slv_rsp.hexokay;
			src_hrdata[i]          = slv_hrdata;
		end
	end

endmodule

/* logic/ahbl_sram.sv */
// Word-addressed AHB-Lite SRAM slave; one write wait state, ERROR at or above MEM_BYTES, single exclusive reservation
`timescale 1ns/1ps

module ahbl_sram (
	input  logic              clk,
	input  logic              rst_n,
	input  ahbl_pkg::aphase_t dst_aphase,
	input  logic              dst_hready,
	input  ahbl_pkg::data_t   dst_hwdata,
	output ahbl_pkg::rsp_t    slv_rsp,
	output ahbl_pkg::data_t   slv_hrdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WWAIT,
		ST_WRITE,
		ST_ERR1,
		ST_ERR2
	} state_e;

	state_e state;
	state_e state_nxt;

	ahbl_pkg::data_t mem [ahbl_pkg::MEM_WORDS];

	// Registered data phase context
	logic                 dp_excl;
	ahbl_pkg::master_id_t dp_master;
	ahbl_pkg::mem_idx_t   dp_idx;

	// Exclusive monitor
	logic                 resv_valid;
	ahbl_pkg::master_id_t resv_master;
	ahbl_pkg::mem_idx_t   resv_idx;

	logic a_range_err;
	logic resv_match;
	logic wr_commit;
	logic rd_done;

	assign a_range_err = dst_aphase.haddr >= ahbl_pkg::MEM_BYTES;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WWAIT: state_nxt = ST_WRITE;
			ST_ERR1:  state_nxt = ST_ERR2;
			default: begin
				if (dst_hready) begin
					if (!dst_aphase.htrans[1]) begin
						state_nxt = ST_IDLE;
					end else if (a_range_err) begin
						state_nxt = ST_ERR1;
					end else if (dst_aphase.hwrite) begin
						state_nxt = ST_WWAIT;
					end else begin
						state_nxt = ST_READ;
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (dst_hready) begin
			dp_excl   <= dst_aphase.hexcl;
			dp_master <= dst_aphase.hmaster;
			dp_idx    <= dst_aphase.haddr[ahbl_pkg::W_MEM_IDX+1:2];
		end
	end

	assign resv_match = resv_valid && (resv_master == dp_master) && (resv_idx == dp_idx);

	// A failed exclusive write leaves memory untouched
	assign wr_commit = (state == ST_WRITE) && dst_hready && (!dp_excl || resv_match);
	assign rd_done   = (state == ST_READ) && dst_hready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ahbl_pkg::MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_commit) begin
			mem[dp_idx] <= dst_hwdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resv_valid  <= 1'b0;
			resv_master <= '0;
			resv_idx    <= '0;
		end else if (rd_done && dp_excl) begin
			resv_valid  <= 1'b1;
			resv_master <= dp_master;
			resv_idx    <= dp_idx;
		end else if (wr_commit && (resv_idx == dp_idx)) begin
			// Any write that lands on the reserved word breaks the reservation
			resv_valid <= 1'b0;
		end
	end

	assign slv_rsp.hready_resp = !(state inside {ST_WWAIT, ST_ERR1});
	assign slv_rsp.hresp       = state inside {ST_ERR1, ST_ERR2};
	assign slv_rsp.hexokay     = (state == ST_READ || (state == ST_WRITE && resv_match)) && dp_excl;
	assign slv_hrdata          = (state == ST_READ) ? mem[dp_idx] : '0;

	// Masters must only issue full-word transfers, there are no byte lanes
	a_word_only: assert property (
		@(posedge clk) disable iff (!rst_n)
		dst_hready && dst_aphase.htrans[1] |-> dst_aphase.hsize == ahbl_pkg::WORD
	) else $error("sub-word transfer reached the SRAM");

endmodule

/* logic/ahbl_arb_top.sv */
// Two-master AHB-Lite arbiter in front of one SRAM slave; masters must tie src_hready to their own hready_resp
`timescale 1ns/1ps

module ahbl_arb_top (
	input  logic                clk,
	input  logic                rst_n,
	input  ahbl_pkg::aphase_t   src_aphase [ahbl_pkg::N_PORTS],
	input  ahbl_pkg::port_vec_t src_hready,
	input  ahbl_pkg::data_t     src_hwdata [ahbl_pkg::N_PORTS],
	output ahbl_pkg::rsp_t      src_rsp [ahbl_pkg::N_PORTS],
	output ahbl_pkg::data_t     src_hrdata [ahbl_pkg::N_PORTS]
);

	// Buffered or live address phase per master
	ahbl_pkg::aphase_t   actual_aphase [ahbl_pkg::N_PORTS];

	ahbl_pkg::port_vec_t gnt_a;
	ahbl_pkg::port_vec_t gnt_d;
	ahbl_pkg::port_vec_t buf_wen;
	ahbl_pkg::port_vec_t buf_clr;
	ahbl_pkg::port_vec_t buf_valid;

	// Slave side of the arbiter
	logic                dst_hready;
	ahbl_pkg::aphase_t   dst_aphase;
	ahbl_pkg::data_t     dst_hwdata;
	ahbl_pkg::rsp_t      slv_rsp;
	ahbl_pkg::data_t     slv_hrdata;

	ahbl_arb_ctrl u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.actual_aphase   (actual_aphase),
		.src_hready      (src_hready),
		.slv_hready_resp (slv_rsp.hready_resp),
		.gnt_a           (gnt_a),
		.gnt_d           (gnt_d),
		.buf_wen         (buf_wen),
		.buf_clr         (buf_clr),
		.dst_hready      (dst_hready)
	);

	ahbl_aphase_buf u_buf (
		.clk           (clk),
		.rst_n         (rst_n),
		.src_aphase    (src_aphase),
		.buf_wen       (buf_wen),
		.buf_clr       (buf_clr),
		.actual_aphase (actual_aphase),
		.buf_valid     (buf_valid)
	);

	ahbl_port_route u_route (
		.actual_aphase (actual_aphase),
		.gnt_a         (gnt_a),
		.gnt_d         (gnt_d),
		.buf_valid     (buf_valid),
		.src_hwdata    (src_hwdata),
		.slv_rsp       (slv_rsp),
		.slv_hrdata    (slv_hrdata),
		.dst_aphase    (dst_aphase),
		.dst_hwdata    (dst_hwdata),
		.src_rsp       (src_rsp),
		.src_hrdata    (src_hrdata)
	);

	ahbl_sram u_sram (
		.clk        (clk),
		.rst_n      (rst_n),
		.dst_aphase (dst_aphase),
		.dst_hready (dst_hready),
		.dst_hwdata (dst_hwdata),
		.slv_rsp    (slv_rsp),
		.slv_hrdata (slv_hrdata)
	);

endmodule

/* verification/tb_ahbl_arb.sv */
// Replays verification/ahbl_golden.txt line by line; run from the project root, at most 64 lines
`timescale 1ns/1ps

module tb_ahbl_arb;

	localparam int MAX_LINES    = 64;
	localparam int FIELDS       = 9;
	localparam int CYC_PER_LINE = 30;

	// One port's share of a golden line
	typedef struct packed {
		logic                 active;
		logic                 write;
		logic                 excl;
		ahbl_pkg::master_id_t master;
		ahbl_pkg::addr_t      addr;
		ahbl_pkg::data_t      wdata;
		ahbl_pkg::data_t      exp_rdata;
		logic                 exp_hresp;
		logic                 exp_hexokay;
	} xfer_t;

	logic                clk;
	logic                rst_n;
	ahbl_pkg::aphase_t   src_aphase [ahbl_pkg::N_PORTS];
	ahbl_pkg::port_vec_t src_hready;
	ahbl_pkg::data_t     src_hwdata [ahbl_pkg::N_PORTS];
	ahbl_pkg::rsp_t      src_rsp [ahbl_pkg::N_PORTS];
	ahbl_pkg::data_t     src_hrdata [ahbl_pkg::N_PORTS];

	xfer_t       vecs [MAX_LINES][ahbl_pkg::N_PORTS];
	int          n_lines     = 0;
	int          err_cnt     = 0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 0;
	int unsigned lcg_state   = 32'd42;

	ahbl_arb_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.src_aphase (src_aphase),
		.src_hready (src_hready),
		.src_hwdata (src_hwdata),
		.src_rsp    (src_rsp),
		.src_hrdata (src_hrdata)
	);

	always #5 clk = ~clk;

	// Each master ends its address phase on its own hready_resp
	always_comb begin
		for (int i = 0; i < ahbl_pkg::N_PORTS; i++) begin
			src_hready[i] = src_rsp[i].hready_resp;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic drive_idle();
		for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
			src_aphase[p] = '0;
			src_hwdata[p] = '0;
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		string       txt;
		logic [31:0] f [FIELDS * 2];
		fd = $fopen("verification/ahbl_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/ahbl_golden.txt from the working directory");
			$display("SIMULATION FAILED");
			$fatal(1, "missing golden file");
		end
		while ($fgets(txt, fd) != 0) begin
			// Skip column notes and blank lines
			if (txt.len() < 2 || txt[0] == "#") begin
				continue;
			end
			n = $sscanf(txt, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
			if (n != FIELDS * 2 || n_lines >= MAX_LINES) begin
				$display("golden file line %0d is malformed or beyond the line limit", n_lines + 1);
				$display("SIMULATION FAILED");
				$fatal(1, "bad golden file");
			end
			for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
				vecs[n_lines][p].active      = f[FIELDS*p][0];
				vecs[n_lines][p].write       = f[FIELDS*p+1][0];
				vecs[n_lines][p].excl        = f[FIELDS*p+2][0];
				vecs[n_lines][p].master      = f[FIELDS*p+3][7:0];
				vecs[n_lines][p].addr        = f[FIELDS*p+4];
				vecs[n_lines][p].wdata       = f[FIELDS*p+5];
				vecs[n_lines][p].exp_rdata   = f[FIELDS*p+6];
				vecs[n_lines][p].exp_hresp   = f[FIELDS*p+7][0];
				vecs[n_lines][p].exp_hexokay = f[FIELDS*p+8][0];
			end
			n_lines++;
		end
		$fclose(fd);
	endtask

	// Both address phases go out together, write data held until the transfer ends
	task automatic drive_line(input int ln);
		drive_idle();
		for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
			if (vecs[ln][p].active) begin
				src_aphase[p].haddr   = vecs[ln][p].addr;
				src_aphase[p].hwrite  = vecs[ln][p].write;
				src_aphase[p].htrans  = ahbl_pkg::NONSEQ;
				src_aphase[p].hsize   = ahbl_pkg::WORD;
				src_aphase[p].hexcl   = vecs[ln][p].excl;
				src_aphase[p].hmaster = vecs[ln][p].master;
				src_hwdata[p]         = vecs[ln][p].wdata;
			end
		end
	endtask

	task automatic run_line(input int ln);
		ahbl_pkg::port_vec_t active;
		ahbl_pkg::port_vec_t addr_done;
		ahbl_pkg::port_vec_t data_done;
		ahbl_pkg::port_vec_t ends_now;
		ahbl_pkg::port_vec_t seen_hresp;
		ahbl_pkg::rsp_t      got_rsp [ahbl_pkg::N_PORTS];
		ahbl_pkg::data_t     got_rdata [ahbl_pkg::N_PORTS];
		int                  done_cyc [ahbl_pkg::N_PORTS];
		int                  cyc;
		xfer_t               x;
		addr_done  = '0;
		data_done  = '0;
		seen_hresp = '0;
		cyc        = 0;
		for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
			active[p]   = vecs[ln][p].active;
			done_cyc[p] = 0;
		end
		@(posedge clk);
		#1;
		drive_line(ln);
		while ((data_done & active) != active) begin
			// Mid-cycle values are the ones the next rising edge samples
			@(negedge clk);
			ends_now = '0;
			for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
				if (active[p] && !data_done[p]) begin
					if (src_rsp[p].hresp) begin
						seen_hresp[p] = 1'b1;
					end
					if (src_rsp[p].hready_resp && addr_done[p]) begin
						data_done[p] = 1'b1;
						got_rsp[p]   = src_rsp[p];
						got_rdata[p] = src_hrdata[p];
						done_cyc[p]  = cyc;
					end else if (src_rsp[p].hready_resp) begin
						ends_now[p]  = 1'b1;
						addr_done[p] = 1'b1;
					end
				end
			end
			@(posedge clk);
			#1;
			cyc++;
			for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
				if (ends_now[p]) begin
					src_aphase[p].htrans = ahbl_pkg::IDLE;
				end
			end
		end
		drive_idle();
		for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
			x = vecs[ln][p];
			if (x.active) begin
				check_val(seen_hresp[p], x.exp_hresp,
					$sformatf("line %0d port %0d hresp", ln + 1, p));
				check_val(got_rsp[p].hexokay, x.exp_hexokay,
					$sformatf("line %0d port %0d hexokay", ln + 1, p));
				// Read data only means something on a read that completed OKAY
				if (!x.write && !x.exp_hresp) begin
					check_val(got_rdata[p], x.exp_rdata,
						$sformatf("line %0d port %0d hrdata", ln + 1, p));
				end
			end
		end
		if (active == '1) begin
			check_val(done_cyc[0] <= done_cyc[1], 1'b1,
				$sformatf("line %0d port 0 completed after port 1", ln + 1));
		end
	endtask

	initial begin
		int gap;
		clk   = 1'b0;
		rst_n = 1'b0;
		drive_idle();
		load_golden();
		if (n_lines == 0) begin
			$display("golden file holds no transfer lines");
			$display("SIMULATION FAILED");
			$fatal(1, "empty golden file");
		end
		cycle_limit = CYC_PER_LINE * n_lines + 10;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Bus is idle and ready straight out of reset
		@(negedge clk);
		for (int p = 0; p < ahbl_pkg::N_PORTS; p++) begin
			check_val(src_rsp[p].hready_resp, 1'b1, $sformatf("port %0d hready after reset", p));
			check_val(src_rsp[p].hresp, 1'b0, $sformatf("port %0d hresp after reset", p));
		end
		for (int ln = 0; ln < n_lines; ln++) begin
			run_line(ln);
			gap = int'((lcg_next() >> 16) % 4);
			repeat (gap) @(posedge clk);
		end
		if (err_cnt == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* src.f */
logic/ahbl_pkg.sv
logic/ahbl_arb_ctrl.sv
logic/ahbl_aphase_buf.sv
logic/ahbl_port_route.sv
logic/ahbl_sram.sv
logic/ahbl_arb_top.sv
verification/tb_ahbl_arb.sv

/* verification/ahbl_golden.txt */
# per port: active write excl hmaster haddr hwdata exp_hrdata exp_hresp exp_hexokay, all hex
# port 0 fields first, then port 1; exp_hrdata only counts on reads that return OKAY
1 1 0 01 00000000 11111111 00000000 0 0   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 1 0 02 00000004 22222222 00000000 0 0
1 0 0 01 00000000 00000000 11111111 0 0   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 0 02 00000004 00000000 22222222 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 0 02 00000000 00000000 11111111 0 0
1 1 0 01 00000010 a0a0a0a0 00000000 0 0   1 1 0 02 00000014 b1b1b1b1 00000000 0 0
1 0 0 01 00000014 00000000 b1b1b1b1 0 0   1 0 0 02 00000010 00000000 a0a0a0a0 0 0
1 1 0 01 00000020 c0c0c0c0 00000000 0 0   1 1 0 02 00000020 c1c1c1c1 00000000 0 0
1 0 0 01 00000020 00000000 c1c1c1c1 0 0   0 0 0 00 00000000 00000000 00000000 0 0
1 0 0 01 00000000 00000000 11111111 0 0   1 1 0 02 00000024 d1d1d1d1 00000000 0 0
1 1 0 01 00000028 28282828 00000000 0 0   1 0 0 02 00000024 00000000 d1d1d1d1 0 0
1 0 0 01 00000400 00000000 00000000 1 0   1 0 0 02 00000004 00000000 22222222 0 0
1 1 0 01 0000002c 2c2c2c2c 00000000 0 0   1 1 0 02 00000800 deadbeef 00000000 1 0
1 0 0 01 000003fc 00000000 00000000 0 0   1 0 0 02 fffffffc 00000000 00000000 1 0
1 0 0 01 0000002c 00000000 2c2c2c2c 0 0   1 0 0 02 00000000 00000000 11111111 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 0 02 00000028 00000000 28282828 0 0
1 0 1 01 00000040 00000000 00000000 0 1   0 0 0 00 00000000 00000000 00000000 0 0
1 1 1 01 00000040 40404040 00000000 0 1   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 0 02 00000040 00000000 40404040 0 0
1 1 1 01 00000040 41414141 00000000 0 0   0 0 0 00 00000000 00000000 00000000 0 0
1 0 0 01 00000040 00000000 40404040 0 0   0 0 0 00 00000000 00000000 00000000 0 0
1 0 1 01 00000050 00000000 00000000 0 1   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 1 0 02 00000050 55555555 00000000 0 0
1 1 1 01 00000050 50505050 00000000 0 0   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 0 02 00000050 00000000 55555555 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 0 1 02 00000060 00000000 00000000 0 1
1 1 1 01 00000060 60606060 00000000 0 0   0 0 0 00 00000000 00000000 00000000 0 0
0 0 0 00 00000000 00000000 00000000 0 0   1 1 1 02 00000060 61616161 00000000 0 1
1 0 0 01 00000060 00000000 61616161 0 0   0 0 0 00 00000000 00000000 00000000 0 0
1 0 1 01 00000070 00000000 00000000 0 1   1 0 1 02 00000074 00000000 00000000 0 1
1 1 1 01 00000070 70707070 00000000 0 0   1 1 1 02 00000074 74747474 00000000 0 1
1 0 0 01 00000070 00000000 00000000 0 0   1 0 0 02 00000074 00000000 74747474 0 0
